//--- rtl/spectrum_defines.svh
`ifndef SPECTRUM_DEFINES_SVH
`define SPECTRUM_DEFINES_SVH

// transform length of the upstream FFT
`define FFT_LEN 1024

// width of one real or imaginary component
`define SAMPLE_W 32

// log2 of FFT_LEN
`define BIN_W 10

`endif

//--- rtl/spectrum_pkg.sv
`include "spectrum_defines.svh"

package spectrum_pkg;

    // signed FFT component as delivered by the transform
    typedef logic signed [`SAMPLE_W-1:0] sample_t;

    // re^2 + im^2, max 2^63 so no overflow
    typedef logic [2*`SAMPLE_W-1:0] power_t;

    // floor of the square root of a power value
    typedef logic [`SAMPLE_W-1:0] root_t;

    typedef logic [`BIN_W-1:0] bin_t;

    // fifo payload, also the content of one sqrt request
    typedef struct packed {
        bin_t   bin;
        power_t power;
    } bin_power_t;

endpackage

//--- rtl/sqrt_req_if.sv
`timescale 1ns/1ns

// four-phase req/ack link to the square root unit
interface sqrt_req_if import spectrum_pkg::*; ();

    logic   req;
    power_t radicand;
    bin_t   tag;        // bin number, travels with the operand
    logic   ack;
    root_t  root;
    bin_t   root_tag;

    modport requester (
        output req,
        output radicand,
        output tag,
        input  ack,
        input  root,
        input  root_tag
    );

    modport responder (
        input  req,
        input  radicand,
        input  tag,
        output ack,
        output root,
        output root_tag
    );

endinterface

//--- rtl/power_calc.sv
`timescale 1ns/1ns
`include "spectrum_defines.svh"

module power_calc import spectrum_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  sample_t source_real,
    input  sample_t source_imag,
    input  logic    source_sop,
    input  logic    source_valid,
    output power_t  power,
    output logic    power_sop,
    output logic    power_valid
);

    // magnitudes kept unsigned, -2^31 maps to 2^31
    logic [`SAMPLE_W-1:0] abs_re;
    logic [`SAMPLE_W-1:0] abs_im;
    logic [1:0]           sop_dly;
    logic [1:0]           valid_dly;

    // stage one: two's complement to magnitude
    always_ff @(posedge clk) begin
        abs_re <= source_real[`SAMPLE_W-1] ? (~source_real + 1'b1) : source_real;
        abs_im <= source_imag[`SAMPLE_W-1] ? (~source_imag + 1'b1) : source_imag;
    end

    // stage two: sum of squares in full 64-bit width
    always_ff @(posedge clk) begin
        power <= power_t'(abs_re) * power_t'(abs_re)
               + power_t'(abs_im) * power_t'(abs_im);
    end

    // flags follow the data through both stages
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sop_dly   <= '0;
            valid_dly <= '0;
        end else begin
            sop_dly   <= {sop_dly[0], source_sop};
            valid_dly <= {valid_dly[0], source_valid};
        end
    end

    assign power_sop   = sop_dly[1];
    assign power_valid = valid_dly[1];

endmodule

//--- rtl/half_frame_capture.sv
`timescale 1ns/1ns
`include "spectrum_defines.svh"

module half_frame_capture import spectrum_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       capture_start,
    input  power_t     power,
    input  logic       power_sop,
    input  logic       power_valid,
    output logic       push,
    output bin_power_t push_data
);

    // real input gives a symmetric spectrum so the lower half is enough
    localparam bin_t LAST_BIN = bin_t'(`FFT_LEN/2 - 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ARMED,
        S_CAPTURE
    } state_t;

    state_t state;
    bin_t   bin_cnt;    // counts valid bins only
    logic   take_sop;

    // first bin goes out with the sop itself
    assign take_sop  = (state == S_ARMED) && power_valid && power_sop;
    assign push      = take_sop || ((state == S_CAPTURE) && power_valid);
    assign push_data = '{bin: bin_cnt, power: power};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= S_IDLE;
            bin_cnt <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    bin_cnt <= '0;
                    if (capture_start)
                        state <= S_ARMED;
                end
                S_ARMED: begin
                    if (take_sop) begin
                        bin_cnt <= bin_cnt + 1'b1;
                        state   <= S_CAPTURE;
                    end
                end
                S_CAPTURE: begin     // capture_start ignored here
                    if (power_valid) begin
                        if (bin_cnt == LAST_BIN) begin
                            bin_cnt <= '0;
                            state   <= S_IDLE;
                        end else begin
                            bin_cnt <= bin_cnt + 1'b1;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // only the sop bin may leave before the capture state
    a_push_in_capture: assert property (@(posedge clk) disable iff (!rst_n)
        push && state != S_CAPTURE |-> push_data.bin == '0)
        else $error("push outside capture with a nonzero bin");

endmodule

//--- rtl/bin_fifo.sv
`timescale 1ns/1ns
`include "spectrum_defines.svh"

module bin_fifo import spectrum_pkg::*; #(
    parameter type payload_t = bin_power_t,
    parameter int  DEPTH     = `FFT_LEN/2
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t           mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               full;
    logic               do_push;
    logic               do_pop;

    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);
    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign pop_data = mem[rd_ptr];  // head visible without a pop

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> !full)
        else $error("push into full fifo");

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> !empty)
        else $error("pop from empty fifo");

endmodule

//--- rtl/int_sqrt.sv
`timescale 1ns/1ns
`include "spectrum_defines.svh"

module int_sqrt import spectrum_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    sqrt_req_if.responder      req_if
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_CALC,
        S_PUB,
        S_HOLD
    } state_t;

    state_t               state;
    power_t               rad_sh;       // radicand, consumed two bits per step
    logic [`SAMPLE_W+1:0] rem;
    logic [`SAMPLE_W+1:0] rem_sh;
    logic [`SAMPLE_W+1:0] trial;
    root_t                root_r;
    bin_t                 tag_r;
    logic [4:0]           iter;

    // bring down the next bit pair, test against 4*root + 1
    assign rem_sh = {rem[`SAMPLE_W-1:0], rad_sh[2*`SAMPLE_W-1 -: 2]};
    assign trial  = {root_r, 2'b01};

    always_ff @(posedge clk) begin
        case (state)
            S_IDLE: begin
                if (req_if.req) begin   // load
                    rad_sh <= req_if.radicand;
                    tag_r  <= req_if.tag;
                    rem    <= '0;
                    root_r <= '0;
                end
            end
            S_CALC: begin
                rad_sh <= rad_sh << 2;
                if (rem_sh >= trial) begin
                    rem    <= rem_sh - trial;
                    root_r <= {root_r[`SAMPLE_W-2:0], 1'b1};
                end else begin
                    rem    <= rem_sh;
                    root_r <= {root_r[`SAMPLE_W-2:0], 1'b0};
                end
            end
            S_PUB: begin
                req_if.root     <= root_r;
                req_if.root_tag <= tag_r;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            iter       <= '0;
            req_if.ack <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    iter <= '0;
                    if (req_if.req)
                        state <= S_CALC;
                end
                S_CALC: begin
                    iter <= iter + 1'b1;
                    if (iter == 5'd31)
                        state <= S_PUB;  // 32 root bits done
                end
                S_PUB: begin
                    req_if.ack <= 1'b1;
                    state      <= S_HOLD;
                end
                S_HOLD: begin
                    if (!req_if.req) begin
                        req_if.ack <= 1'b0;
                        state      <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    a_ack_held: assert property (@(posedge clk) disable iff (!rst_n)
        req_if.ack && req_if.req |=> req_if.ack)
        else $error("ack dropped before req");

endmodule

//--- rtl/sqrt_sequencer.sv
`timescale 1ns/1ns

module sqrt_sequencer import spectrum_pkg::*; (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           empty,
    input  bin_power_t     pop_data,
    output logic           pop,
    sqrt_req_if.requester  req_if,
    output root_t          magnitude,
    output bin_t           magnitude_bin,
    output logic           magnitude_valid
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_WAIT_LOW
    } state_t;

    state_t state;
    logic   done;

    assign done = (state == S_REQ) && req_if.ack;
    assign pop  = done;     // head leaves once its result is taken

    // operand stays frozen while req is up
    always_ff @(posedge clk) begin
        if (state == S_IDLE && !empty) begin
            req_if.radicand <= pop_data.power;
            req_if.tag      <= pop_data.bin;
        end
        if (done) begin
            magnitude     <= req_if.root;
            magnitude_bin <= req_if.root_tag;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state           <= S_IDLE;
            req_if.req      <= 1'b0;
            magnitude_valid <= 1'b0;
        end else begin
            magnitude_valid <= done;     // single cycle pulse
            case (state)
                S_IDLE: begin
                    if (!empty) begin
                        req_if.req <= 1'b1;
                        state      <= S_REQ;
                    end
                end
                S_REQ: begin
                    if (req_if.ack) begin
                        req_if.req <= 1'b0;
                        state      <= S_WAIT_LOW;
                    end
                end
                S_WAIT_LOW: begin
                    if (!req_if.ack)
                        state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    a_req_after_ack_low: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(req_if.req) |-> !req_if.ack)
        else $error("req raised while ack still high");

endmodule

//--- rtl/spectrum_magnitude.sv
`timescale 1ns/1ns
`include "spectrum_defines.svh"

module spectrum_magnitude import spectrum_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  sample_t source_real,
    input  sample_t source_imag,
    input  logic    source_sop,
    input  logic    source_valid,
    input  logic    capture_start,  // one cycle arm pulse
    output root_t   magnitude,
    output bin_t    magnitude_bin,
    output logic    magnitude_valid
);

    power_t     power;
    logic       power_sop;
    logic       power_valid;
    logic       push;
    bin_power_t push_data;
    logic       pop;
    bin_power_t pop_data;
    logic       empty;

    sqrt_req_if sqrt_if ();

    power_calc power_calc_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .source_real  (source_real),
        .source_imag  (source_imag),
        .source_sop   (source_sop),
        .source_valid (source_valid),
        .power        (power),
        .power_sop    (power_sop),
        .power_valid  (power_valid)
    );

    half_frame_capture capture_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .capture_start (capture_start),
        .power         (power),
        .power_sop     (power_sop),
        .power_valid   (power_valid),
        .push          (push),
        .push_data     (push_data)
    );

    // sized for a whole half frame
    bin_fifo #(
        .payload_t (bin_power_t),
        .DEPTH     (`FFT_LEN/2)
    ) fifo_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .pop_data  (pop_data),
        .empty     (empty)
    );

    int_sqrt sqrt_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .req_if (sqrt_if.responder)
    );

    sqrt_sequencer seq_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .empty           (empty),
        .pop_data        (pop_data),
        .pop             (pop),
        .req_if          (sqrt_if.requester),
        .magnitude       (magnitude),
        .magnitude_bin   (magnitude_bin),
        .magnitude_valid (magnitude_valid)
    );

endmodule

//--- verif/tb_spectrum_magnitude.sv
`timescale 1ns/1ns
`include "spectrum_defines.svh"

module tb_spectrum_magnitude import spectrum_pkg::*; ();

    localparam int HALF       = `FFT_LEN/2;
    localparam int NUM_FRAMES = 7;     // input frames sent over all tests
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * HALF * 40
                                  + NUM_FRAMES * `FFT_LEN * 2 + 2000;

    logic    clk;
    logic    rst_n;
    sample_t source_real;
    sample_t source_imag;
    logic    source_sop;
    logic    source_valid;
    logic    capture_start;
    root_t   magnitude;
    bin_t    magnitude_bin;
    logic    magnitude_valid;

    logic [31:0] rng_state;
    root_t       exp_root[$];
    bin_t        exp_bin[$];
    int          m_state;       // 0 idle, 1 armed, 2 capturing
    int          m_bin;
    string       cur_test;
    int          errors;
    int          results_seen;
    bin_t        last_bin;
    int          test_err0;
    int          test_res0;
    int          tests_passed;
    int          tests_failed;

    spectrum_magnitude dut_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .source_real     (source_real),
        .source_imag     (source_imag),
        .source_sop      (source_sop),
        .source_valid    (source_valid),
        .capture_start   (capture_start),
        .magnitude       (magnitude),
        .magnitude_bin   (magnitude_bin),
        .magnitude_valid (magnitude_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("watchdog expired in %s, results stopped arriving", cur_test);
        $display("Test FAILED");
        $finish;
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // squared magnitude in 64 bits where |-2^31| fits once widened
    function automatic logic [63:0] square_sum(sample_t re, sample_t im);
        longint      a;
        longint      b;
        logic [63:0] ua;
        logic [63:0] ub;
        a = re;
        b = im;
        if (a < 0)
            a = -a;
        if (b < 0)
            b = -b;
        ua = a;
        ub = b;
        return ua * ua + ub * ub;
    endfunction

    // greedy bit guess from the msb down
    function automatic root_t floor_sqrt(logic [63:0] n);
        logic [31:0] res;
        logic [63:0] cand;
        res = '0;
        for (int b = 31; b >= 0; b--) begin
            cand = {32'd0, res | (32'd1 << b)};
            if (cand * cand <= n)
                res = res | (32'd1 << b);
        end
        return res;
    endfunction

    task automatic check_root(input string name, input root_t exp, input root_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: magnitude expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bin(input string name, input bin_t exp, input bin_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: bin expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    // arms, waits for sop and takes HALF valid samples
    function automatic void model_step(sample_t re, sample_t im, logic sop,
                                       logic valid, logic arm);
        if (arm && m_state == 0)
            m_state = 1;
        if (valid) begin
            if (m_state == 1 && sop) begin
                m_state = 2;
                m_bin   = 0;
            end
            if (m_state == 2) begin
                exp_root.push_back(floor_sqrt(square_sum(re, im)));
                exp_bin.push_back(bin_t'(m_bin));
                m_bin++;
                if (m_bin == HALF)
                    m_state = 0;
            end
        end
    endfunction

    task automatic drive_cycle(input sample_t re, input sample_t im, input logic sop,
                               input logic valid, input logic arm);
        @(posedge clk);
        source_real   <= re;
        source_imag   <= im;
        source_sop    <= sop;
        source_valid  <= valid;
        capture_start <= arm;
        model_step(re, im, sop, valid, arm);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_cycle('0, '0, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic arm_capture();
        drive_cycle('0, '0, 1'b0, 1'b0, 1'b1);
        idle_cycles(4);     // arm settles before the frame
    endtask

    task automatic pick_extreme(input int idx, output sample_t re, output sample_t im);
        logic [31:0] r;
        r = next_random();
        case (idx % 8)
            0: begin        // sum is 2^63
                re = 32'h8000_0000;
                im = 32'h8000_0000;
            end
            1: begin
                re = 32'h7fff_ffff;
                im = 32'h7fff_ffff;
            end
            2: begin
                re = '0;
                im = '0;
            end
            3: begin
                re = 32'sd3;
                im = -32'sd4;
            end
            4: begin
                re = 32'h8000_0000;
                im = '0;
            end
            5: begin
                re = 32'h7fff_ffff;
                im = 32'h8000_0000;
            end
            6: begin        // perfect square
                re = r;
                im = '0;
            end
            default: begin
                re = sample_t'({4'd0, r[27:0]} * 3);   // 3-4-5 triple
                im = sample_t'({4'd0, r[27:0]} * 4);
            end
        endcase
    endtask

    task automatic send_frame(input bit extreme, input int gap_pct,
                              input bit stray_sop, input int arm_at);
        int          n_valid;
        logic [31:0] r;
        logic        v;
        logic        sop;
        logic        arm;
        sample_t     re;
        sample_t     im;
        n_valid = 0;
        while (n_valid < `FFT_LEN) begin
            r   = next_random();
            v   = (r % 100) >= gap_pct;
            sop = v ? (n_valid == 0) : (stray_sop && r[31]);
            arm = v && (n_valid == arm_at);
            if (extreme && v) begin
                pick_extreme(n_valid, re, im);
            end else begin
                re = next_random();
                im = next_random();
            end
            drive_cycle(re, im, sop, v, arm);
            if (v)
                n_valid++;
        end
        idle_cycles(1);
    endtask

    task automatic wait_drain();
        while (exp_root.size() != 0)
            idle_cycles(1);
        idle_cycles(100);   // room for stray results
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_err0 = errors;
        test_res0 = results_seen;
    endtask

    task automatic finish_test(input int exp_results);
        int got;
        got = results_seen - test_res0;
        if (got != exp_results) begin
            $display("%s: %0d results arrived where %0d were due", cur_test, got, exp_results);
            errors++;
        end
        if (errors == test_err0) begin
            tests_passed++;
            $display("%s: pass, %0d results", cur_test, got);
        end else begin
            tests_failed++;
            $display("%s: fail, %0d errors", cur_test, errors - test_err0);
        end
    endtask

    // outputs read at the falling edge away from the driving edge
    always @(negedge clk) begin
        if (rst_n && magnitude_valid === 1'b1) begin
            results_seen++;
            last_bin = magnitude_bin;
            if (exp_root.size() == 0) begin
                $display("%s: result for bin %0d arrived with none due",
                         cur_test, magnitude_bin);
                errors++;
            end else begin
                check_root(cur_test, exp_root.pop_front(), magnitude);
                check_bin(cur_test, exp_bin.pop_front(), magnitude_bin);
            end
        end else if (rst_n && magnitude_valid !== 1'b0) begin
            $display("%s: magnitude_valid is unknown", cur_test);
            errors++;
        end
    end

    initial begin
        rng_state     = 32'hcdc6;
        m_state       = 0;
        m_bin         = 0;
        cur_test      = "reset";
        errors        = 0;
        results_seen  = 0;
        last_bin      = '0;
        tests_passed  = 0;
        tests_failed  = 0;
        rst_n         = 1'b0;
        source_real   = '0;
        source_imag   = '0;
        source_sop    = 1'b0;
        source_valid  = 1'b0;
        capture_start = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        start_test("random_frame");
        if (magnitude_valid !== 1'b0) begin
            $display("%s: magnitude_valid is not low after reset", cur_test);
            errors++;
        end
        idle_cycles(20);
        arm_capture();
        send_frame(1'b0, 30, 1'b0, -1);
        wait_drain();
        finish_test(HALF);

        start_test("half_frame");
        arm_capture();
        repeat (30) drive_cycle(next_random(), next_random(), 1'b0, 1'b1, 1'b0);  // before sop
        send_frame(1'b0, 10, 1'b0, -1);
        wait_drain();
        check_bin(cur_test, bin_t'(HALF - 1), last_bin);
        finish_test(HALF);

        start_test("extreme_values");
        arm_capture();
        send_frame(1'b1, 0, 1'b0, -1);
        wait_drain();
        finish_test(HALF);

        // arm pulse in mid capture, then an unarmed frame, then a real re-arm
        start_test("rearm");
        arm_capture();
        send_frame(1'b0, 20, 1'b0, 100);
        wait_drain();
        send_frame(1'b0, 20, 1'b0, -1);
        wait_drain();
        arm_capture();
        send_frame(1'b0, 20, 1'b0, -1);
        wait_drain();
        finish_test(2 * HALF);

        start_test("valid_gaps");
        arm_capture();
        send_frame(1'b0, 50, 1'b1, -1);
        wait_drain();
        finish_test(HALF);

        $display("tests passed: %0d, failed: %0d, errors: %0d",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

//--- spectrum_magnitude.f
+incdir+rtl
rtl/spectrum_pkg.sv
rtl/sqrt_req_if.sv
rtl/power_calc.sv
rtl/half_frame_capture.sv
rtl/bin_fifo.sv
rtl/int_sqrt.sv
rtl/sqrt_sequencer.sv
rtl/spectrum_magnitude.sv
verif/tb_spectrum_magnitude.sv

//--- Bender.yml
package:
  name: spectrum_magnitude

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/spectrum_pkg.sv
      - rtl/sqrt_req_if.sv
      - rtl/power_calc.sv
      - rtl/half_frame_capture.sv
      - rtl/bin_fifo.sv
      - rtl/int_sqrt.sv
      - rtl/sqrt_sequencer.sv
      - rtl/spectrum_magnitude.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/tb_spectrum_magnitude.sv
